// File: logic/rv_pkg.sv
package rv_pkg;

  // ========================================
  // Widths
  // ========================================
  parameter int xlen       = 32;
  parameter int reg_addr_w = 5;

  // Opcode field values of the kept subset
  typedef enum logic [6:0] {
    op_alu_reg = 7'b0110011,
    op_alu_imm = 7'b0010011,
    op_load    = 7'b0000011,
    op_store   = 7'b0100011,
    op_branch  = 7'b1100011,
    op_jal     = 7'b1101111,
    op_jalr    = 7'b1100111,
    op_lui     = 7'b0110111,
    op_auipc   = 7'b0010111
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_mul,
    alu_sll,
    alu_srl,
    alu_pass_b, // Operand b straight through
    alu_link,   // Result is pc + 4, always redirects
    beq,
    bne,
    blt,
    bge
  } alu_op_e;

  typedef enum logic [1:0] {
    mem_none,
    mem_load,
    mem_store
  } mem_op_e;

  // addi x0, x0, 0
  parameter logic [31:0] nop_instr = 32'h0000_0013;

  // ========================================
  // Wishbone
  // ========================================
  parameter int          wb_sel_w   = 4;
  parameter logic [3:0]  wb_sel_all = 4'hf; // Word access only

endpackage

// File: logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
  parameter int imem_depth = 256,
  parameter logic [31:0] reset_pc = 32'h0
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          run,
  input  logic                          prog_we,
  input  logic [$clog2(imem_depth)-1:0] prog_addr,
  input  logic [rv_pkg::xlen-1:0]       prog_data,
  input  logic                          stall,
  input  logic                          freeze,
  input  logic                          redirect,
  input  logic [rv_pkg::xlen-1:0]       redirect_pc,
  output logic [rv_pkg::xlen-1:0]       if_instr,
  output logic [rv_pkg::xlen-1:0]       if_pc
);

  localparam int aw = $clog2(imem_depth);

  logic [rv_pkg::xlen-1:0] imem [imem_depth];
  logic [rv_pkg::xlen-1:0] pc;

  // Program load port
  always_ff @(posedge clock) begin
    if (prog_we) imem[prog_addr] <= prog_data;
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      pc       <= reset_pc;
      if_instr <= rv_pkg::nop_instr;
      if_pc    <= reset_pc;
    end else if (freeze) begin
      // Memory stage busy, hold everything
    end else if (redirect) begin
      pc       <= redirect_pc;
      if_instr <= rv_pkg::nop_instr; // Drop the wrong-path fetch
    end else if (stall) begin
      // Load-use bubble, keep IF/ID
    end else if (run) begin
      pc       <= pc + 32'd4;
      if_instr <= imem[pc[aw+1:2]];
      if_pc    <= pc;
    end else begin
      if_instr <= rv_pkg::nop_instr; // Not started yet
    end
  end

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic                          clock,
  input  logic                          reset,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2,
  input  logic [rv_pkg::reg_addr_w-1:0] wb_rd,
  input  logic [rv_pkg::xlen-1:0]       wb_value,
  input  logic                          wb_reg_write,
  output logic [rv_pkg::xlen-1:0]       rs1_val,
  output logic [rv_pkg::xlen-1:0]       rs2_val
);

  logic [rv_pkg::xlen-1:0] regs [1:31]; // x0 is not stored

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (wb_reg_write && wb_rd != '0) begin
      regs[wb_rd] <= wb_value;
    end
  end

  // Same-cycle write is visible to the reader
  assign rs1_val = (rs1 == '0) ? '0 :
                   (wb_reg_write && wb_rd == rs1) ? wb_value : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 :
                   (wb_reg_write && wb_rd == rs2) ? wb_value : regs[rs2];

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic                          clock,
  input  logic                          reset,
  input  logic [rv_pkg::xlen-1:0]       if_instr,
  input  logic [rv_pkg::xlen-1:0]       if_pc,
  input  logic [rv_pkg::xlen-1:0]       rs1_val,
  input  logic [rv_pkg::xlen-1:0]       rs2_val,
  input  logic                          freeze,
  input  logic                          redirect,
  output logic [rv_pkg::reg_addr_w-1:0] rs1,
  output logic [rv_pkg::reg_addr_w-1:0] rs2,
  output logic                          stall,
  output logic [rv_pkg::xlen-1:0]       id_pc,
  output logic [rv_pkg::xlen-1:0]       id_rs1_val,
  output logic [rv_pkg::xlen-1:0]       id_rs2_val,
  output logic [rv_pkg::reg_addr_w-1:0] id_rs1,
  output logic [rv_pkg::reg_addr_w-1:0] id_rs2,
  output logic [rv_pkg::reg_addr_w-1:0] id_rd,
  output logic [rv_pkg::xlen-1:0]       id_imm,
  output rv_pkg::alu_op_e               id_alu_op,
  output rv_pkg::mem_op_e               id_mem_op,
  output logic                          id_reg_write,
  output logic                          id_uses_imm
);

  rv_pkg::opcode_e         opcode;
  rv_pkg::alu_op_e         alu_op;
  rv_pkg::mem_op_e         mem_op;
  logic [rv_pkg::xlen-1:0] imm;
  logic                    reg_write, uses_imm, uses_rs1, uses_rs2;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [4:0]              rd;

  assign opcode = rv_pkg::opcode_e'(if_instr[6:0]);
  assign funct3 = if_instr[14:12];
  assign funct7 = if_instr[31:25];
  assign rd     = if_instr[11:7];

  // ========================================
  // Control decode
  // ========================================
  always_comb begin
    alu_op    = rv_pkg::alu_add;
    mem_op    = rv_pkg::mem_none;
    imm       = {{20{if_instr[31]}}, if_instr[31:20]}; // I format
    reg_write = 1'b0;
    uses_imm  = 1'b1;
    uses_rs1  = 1'b1;
    uses_rs2  = 1'b0;
    case (opcode)
      rv_pkg::op_alu_reg: begin
        reg_write = 1'b1;
        uses_imm  = 1'b0;
        uses_rs2  = 1'b1;
        if (funct7 == 7'b0000001) alu_op = rv_pkg::alu_mul;
        else if (funct7[5])       alu_op = rv_pkg::alu_sub;
      end
      rv_pkg::op_alu_imm: begin
        reg_write = 1'b1;
        if (funct3 == 3'b001)      alu_op = rv_pkg::alu_sll;
        else if (funct3 == 3'b101) alu_op = rv_pkg::alu_srl;
      end
      rv_pkg::op_load: begin
        reg_write = 1'b1;
        mem_op    = rv_pkg::mem_load;
      end
      rv_pkg::op_store: begin
        mem_op   = rv_pkg::mem_store;
        uses_rs2 = 1'b1;
        imm      = {{20{if_instr[31]}}, funct7, rd}; // S format
      end
      rv_pkg::op_branch: begin
        uses_imm = 1'b0;
        uses_rs2 = 1'b1;
        imm = {{20{if_instr[31]}}, if_instr[7], if_instr[30:25], if_instr[11:8], 1'b0};
        case (funct3)
          3'b000:  alu_op = rv_pkg::beq;
          3'b001:  alu_op = rv_pkg::bne;
          3'b100:  alu_op = rv_pkg::blt;
          default: alu_op = rv_pkg::bge;
        endcase
      end
      rv_pkg::op_jal: begin
        // Absolute target, rs1 forced to x0 so execute adds zero
        alu_op    = rv_pkg::alu_link;
        reg_write = 1'b1;
        uses_rs1  = 1'b0;
        imm = if_pc + {{12{if_instr[31]}}, if_instr[19:12], if_instr[20],
                       if_instr[30:21], 1'b0};
      end
      rv_pkg::op_jalr: begin
        alu_op    = rv_pkg::alu_link;
        reg_write = 1'b1;
      end
      rv_pkg::op_lui, rv_pkg::op_auipc: begin
        alu_op    = rv_pkg::alu_pass_b;
        reg_write = 1'b1;
        uses_rs1  = 1'b0;
        imm = {if_instr[31:12], 12'b0} + ((opcode == rv_pkg::op_auipc) ? if_pc : '0);
      end
      default: uses_rs1 = 1'b0; // Unknown encoding acts as a bubble
    endcase
    if (rd == '0) reg_write = 1'b0;
  end

  assign rs1 = uses_rs1 ? if_instr[19:15] : '0;
  assign rs2 = uses_rs2 ? if_instr[24:20] : '0;

  // Load-use hazard against the instruction in ID/EX
  assign stall = (id_mem_op == rv_pkg::mem_load) && (id_rd != '0) &&
                 ((rs1 == id_rd) || (rs2 == id_rd));

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      id_alu_op    <= rv_pkg::alu_add;
      id_mem_op    <= rv_pkg::mem_none;
      id_reg_write <= 1'b0;
      id_rd        <= '0;
    end else if (!freeze) begin
      if (stall || redirect) begin
        id_alu_op    <= rv_pkg::alu_add; // Bubble
        id_mem_op    <= rv_pkg::mem_none;
        id_reg_write <= 1'b0;
        id_rd        <= '0;
      end else begin
        id_alu_op    <= alu_op;
        id_mem_op    <= mem_op;
        id_reg_write <= reg_write;
        id_rd        <= rd;
      end
    end
  end

  // Payload fields
  always_ff @(posedge clock) begin
    if (!freeze) begin
      id_pc       <= if_pc;
      id_rs1_val  <= rs1_val;
      id_rs2_val  <= rs2_val;
      id_rs1      <= rs1;
      id_rs2      <= rs2;
      id_imm      <= imm;
      id_uses_imm <= uses_imm;
    end
  end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          freeze,
  input  logic [rv_pkg::xlen-1:0]       id_pc,
  input  logic [rv_pkg::xlen-1:0]       id_rs1_val,
  input  logic [rv_pkg::xlen-1:0]       id_rs2_val,
  input  logic [rv_pkg::reg_addr_w-1:0] id_rs1,
  input  logic [rv_pkg::reg_addr_w-1:0] id_rs2,
  input  logic [rv_pkg::reg_addr_w-1:0] id_rd,
  input  logic [rv_pkg::xlen-1:0]       id_imm,
  input  rv_pkg::alu_op_e               id_alu_op,
  input  rv_pkg::mem_op_e               id_mem_op,
  input  logic                          id_reg_write,
  input  logic                          id_uses_imm,
  input  logic [rv_pkg::reg_addr_w-1:0] mem_rd,
  input  logic [rv_pkg::xlen-1:0]       mem_value,
  input  logic                          mem_reg_write,
  input  logic [rv_pkg::reg_addr_w-1:0] wb_rd,
  input  logic [rv_pkg::xlen-1:0]       wb_value,
  input  logic                          wb_reg_write,
  output logic                          redirect,
  output logic [rv_pkg::xlen-1:0]       redirect_pc,
  output logic [rv_pkg::reg_addr_w-1:0] ex_rd,
  output logic [rv_pkg::xlen-1:0]       ex_result,
  output logic [rv_pkg::xlen-1:0]       ex_store_data,
  output rv_pkg::mem_op_e               ex_mem_op,
  output logic                          ex_reg_write
);

  logic [rv_pkg::xlen-1:0] a, b, op_b, result, jump_pc;
  logic                    taken;

  // ========================================
  // Forwarding, nearest producer first
  // ========================================
  always_comb begin
    if (mem_reg_write && mem_rd != '0 && mem_rd == id_rs1) a = mem_value;
    else if (wb_reg_write && wb_rd != '0 && wb_rd == id_rs1) a = wb_value;
    else a = id_rs1_val;
    if (mem_reg_write && mem_rd != '0 && mem_rd == id_rs2) b = mem_value;
    else if (wb_reg_write && wb_rd != '0 && wb_rd == id_rs2) b = wb_value;
    else b = id_rs2_val;
  end

  assign op_b    = id_uses_imm ? id_imm : b;
  assign jump_pc = (a + id_imm) & ~32'd1; // JAL arrives with a zero base

  always_comb begin
    result = '0;
    taken  = 1'b0;
    case (id_alu_op)
      rv_pkg::alu_add:    result = a + op_b;
      rv_pkg::alu_sub:    result = a - op_b;
      rv_pkg::alu_mul:    result = a * op_b;
      rv_pkg::alu_sll:    result = a << op_b[4:0];
      rv_pkg::alu_srl:    result = a >> op_b[4:0];
      rv_pkg::alu_pass_b: result = op_b;
      rv_pkg::alu_link:   result = id_pc + 32'd4;
      rv_pkg::beq:        taken  = (a == b);
      rv_pkg::bne:        taken  = (a != b);
      rv_pkg::blt:        taken  = ($signed(a) < $signed(b));
      rv_pkg::bge:        taken  = ($signed(a) >= $signed(b));
      default:            result = '0;
    endcase
  end

  assign redirect    = taken || (id_alu_op == rv_pkg::alu_link);
  assign redirect_pc = taken ? id_pc + id_imm : jump_pc;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ex_mem_op    <= rv_pkg::mem_none;
      ex_reg_write <= 1'b0;
      ex_rd        <= '0;
    end else if (!freeze) begin
      ex_mem_op    <= id_mem_op;
      ex_reg_write <= id_reg_write;
      ex_rd        <= id_rd;
    end
  end

  always_ff @(posedge clock) begin
    if (!freeze) begin
      ex_result     <= result;
      ex_store_data <= b; // Forwarded rs2, before the immediate mux
    end
  end

endmodule

// File: logic/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
  input  logic                          clock,
  input  logic                          reset,
  input  logic [rv_pkg::reg_addr_w-1:0] ex_rd,
  input  logic [rv_pkg::xlen-1:0]       ex_result,
  input  logic [rv_pkg::xlen-1:0]       ex_store_data,
  input  rv_pkg::mem_op_e               ex_mem_op,
  input  logic                          ex_reg_write,
  input  logic [rv_pkg::xlen-1:0]       wb_dat_i,
  input  logic                          wb_ack,
  output logic                          wb_cyc,
  output logic                          wb_stb,
  output logic                          wb_we,
  output logic [rv_pkg::xlen-1:0]       wb_adr,
  output logic [rv_pkg::xlen-1:0]       wb_dat_o,
  output logic [rv_pkg::wb_sel_w-1:0]   wb_sel,
  output logic                          freeze,
  output logic [rv_pkg::reg_addr_w-1:0] mem_rd,
  output logic [rv_pkg::xlen-1:0]       mem_value,
  output logic                          mem_reg_write,
  output logic [rv_pkg::reg_addr_w-1:0] wb_rd,
  output logic [rv_pkg::xlen-1:0]       wb_value,
  output logic                          wb_reg_write
);

  typedef enum logic {idle, wait_ack} bus_state_e;

  bus_state_e state;
  logic       done;

  assign done = (state == wait_ack) && wb_ack;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= idle;
    end else if (state == idle && ex_mem_op != rv_pkg::mem_none) begin
      state <= wait_ack;
    end else if (done) begin
      state <= idle; // Bus drops for one cycle after the ack
    end
  end

  // Address and data come straight from EX/MEM, which is frozen meanwhile
  assign wb_cyc   = (state == wait_ack);
  assign wb_stb   = (state == wait_ack);
  assign wb_we    = (state == wait_ack) && (ex_mem_op == rv_pkg::mem_store);
  assign wb_adr   = ex_result;
  assign wb_dat_o = ex_store_data;
  assign wb_sel   = rv_pkg::wb_sel_all;

  assign freeze = (ex_mem_op != rv_pkg::mem_none) && !done;

  // Loads never reach a consumer from here, the load-use bubble sees to that
  assign mem_rd        = ex_rd;
  assign mem_value     = ex_result;
  assign mem_reg_write = ex_reg_write;

  // ========================================
  // MEM/WB register
  // ========================================
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wb_reg_write <= 1'b0;
    end else if (!freeze) begin
      wb_reg_write <= ex_reg_write;
    end
  end

  always_ff @(posedge clock) begin
    if (!freeze) begin
      wb_rd    <= ex_rd;
      wb_value <= (ex_mem_op == rv_pkg::mem_load) ? wb_dat_i : ex_result;
    end
  end

endmodule

// File: logic/rv_pipeline_top.sv
`timescale 1ns/1ps

module rv_pipeline_top #(
  parameter int imem_depth = 256,
  parameter logic [31:0] reset_pc = 32'h0
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          run,
  input  logic                          prog_we,
  input  logic [$clog2(imem_depth)-1:0] prog_addr,
  input  logic [rv_pkg::xlen-1:0]       prog_data,
  output logic                          wb_cyc,
  output logic                          wb_stb,
  output logic                          wb_we,
  output logic [rv_pkg::xlen-1:0]       wb_adr,
  output logic [rv_pkg::xlen-1:0]       wb_dat_o,
  output logic [rv_pkg::wb_sel_w-1:0]   wb_sel,
  input  logic [rv_pkg::xlen-1:0]       wb_dat_i,
  input  logic                          wb_ack
);

  logic [rv_pkg::xlen-1:0]       if_instr, if_pc, rs1_val, rs2_val, redirect_pc;
  logic [rv_pkg::xlen-1:0]       id_pc, id_rs1_val, id_rs2_val, id_imm;
  logic [rv_pkg::xlen-1:0]       ex_result, ex_store_data, mem_value, wb_value;
  logic [rv_pkg::reg_addr_w-1:0] rs1, rs2, id_rs1, id_rs2, id_rd, ex_rd, mem_rd, wb_rd;
  logic                          stall, freeze, redirect, id_reg_write, id_uses_imm;
  logic                          ex_reg_write, mem_reg_write, wb_reg_write;
  rv_pkg::alu_op_e               id_alu_op;
  rv_pkg::mem_op_e               id_mem_op, ex_mem_op;

  fetch_stage #(.imem_depth(imem_depth), .reset_pc(reset_pc)) u_fetch_stage (
    .clock, .reset, .run, .prog_we, .prog_addr, .prog_data, .stall, .freeze,
    .redirect, .redirect_pc, .if_instr, .if_pc
  );

  register_file u_register_file (
    .clock, .reset, .rs1, .rs2, .wb_rd, .wb_value, .wb_reg_write, .rs1_val, .rs2_val
  );

  decode_stage u_decode_stage (
    .clock, .reset, .if_instr, .if_pc, .rs1_val, .rs2_val, .freeze, .redirect,
    .rs1, .rs2, .stall, .id_pc, .id_rs1_val, .id_rs2_val, .id_rs1, .id_rs2, .id_rd,
    .id_imm, .id_alu_op, .id_mem_op, .id_reg_write, .id_uses_imm
  );

  execute_stage u_execute_stage (
    .clock, .reset, .freeze, .id_pc, .id_rs1_val, .id_rs2_val, .id_rs1, .id_rs2,
    .id_rd, .id_imm, .id_alu_op, .id_mem_op, .id_reg_write, .id_uses_imm,
    .mem_rd, .mem_value, .mem_reg_write, .wb_rd, .wb_value, .wb_reg_write,
    .redirect, .redirect_pc, .ex_rd, .ex_result, .ex_store_data, .ex_mem_op,
    .ex_reg_write
  );

  memory_stage u_memory_stage (
    .clock, .reset, .ex_rd, .ex_result, .ex_store_data, .ex_mem_op, .ex_reg_write,
    .wb_dat_i, .wb_ack, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_o, .wb_sel,
    .freeze, .mem_rd, .mem_value, .mem_reg_write, .wb_rd, .wb_value, .wb_reg_write
  );

endmodule

// File: include/rv_tb_model.svh
`ifndef RV_TB_MODEL_SVH
`define RV_TB_MODEL_SVH

// 32-bit xorshift, state must be nonzero
function automatic logic [31:0] xorshift32(inout logic [31:0] state);
  state ^= state << 13;
  state ^= state >> 17;
  state ^= state << 5;
  return state;
endfunction

// ========================================
// Random program, 40 body words then a dump
// ========================================
function automatic void gen_program(ref logic [31:0] prog [$], inout logic [31:0] seed);
  logic [31:0] r;
  logic [4:0]  rd, s1, s2;
  logic [12:0] boff;
  logic [20:0] joff;
  logic [11:0] wimm;
  prog.delete();
  for (int i = 0; i < 40; i++) begin
    r    = xorshift32(seed);
    rd   = r[8:4];
    s1   = r[13:9];
    s2   = r[18:14];
    boff = 13'((1 + ((r[21:20] + 1) < 40 - i ? r[21:20] : 0)) * 4); // Forward only
    joff = 21'(boff);
    wimm = 12'({r[25:20], 2'b00}); // Word in the 64-word window
    case (r[3:0] % 14)
      0:  prog.push_back({7'h00, s2, s1, 3'd0, rd, 7'h33});            // add
      1:  prog.push_back({7'h20, s2, s1, 3'd0, rd, 7'h33});            // sub
      2:  prog.push_back({7'h01, s2, s1, 3'd0, rd, 7'h33});            // mul
      3:  prog.push_back({r[31:20], s1, 3'd0, rd, 7'h13});             // addi
      4:  prog.push_back({7'h00, r[24:20], s1, 3'd1, rd, 7'h13});      // slli
      5:  prog.push_back({7'h00, r[24:20], s1, 3'd5, rd, 7'h13});      // srli
      6:  prog.push_back({wimm, 5'd0, 3'd2, rd, 7'h03});               // lw
      7:  prog.push_back({wimm[11:5], s2, 5'd0, 3'd2, wimm[4:0], 7'h23}); // sw
      8:  prog.push_back({r[31:12], rd, 7'h37});                       // lui
      9:  prog.push_back({r[31:12], rd, 7'h17});                       // auipc
      10: prog.push_back({boff[12], boff[10:5], s2, s1, r[31:29] & 3'b101,
                          boff[4:1], boff[11], 7'h63});                // branch
      11: prog.push_back({boff[12], boff[10:5], s2, s1, 3'b100 | r[29],
                          boff[4:1], boff[11], 7'h63});                // blt or bge
      12: prog.push_back({joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'h6f});
      default: prog.push_back({12'(i * 4) + boff[11:0], 5'd0, 3'd0, rd, 7'h67}); // jalr
    endcase
  end
  for (int x = 1; x < 32; x++) begin
    wimm = 12'(256 + x * 4);
    prog.push_back({wimm[11:5], 5'(x), 5'd0, 3'd2, wimm[4:0], 7'h23});
  end
  prog.push_back(32'h0000_006f); // jal x0, 0
endfunction

// Sequential reference, records every store in program order
function automatic void run_model(ref logic [31:0] prog [$], ref logic [31:0] mem [128],
                                  ref logic [31:0] st_adr [$], ref logic [31:0] st_dat [$]);
  logic [31:0] x [32];
  logic [31:0] pc, nxt, ins, a, b, ii, si, bi, ji;
  x  = '{default: '0};
  pc = 32'h0;
  forever begin
    ins = prog[pc >> 2];
    a   = x[ins[19:15]];
    b   = x[ins[24:20]];
    ii  = {{20{ins[31]}}, ins[31:20]};
    si  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    bi  = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    ji  = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    nxt = pc + 4;
    case (rv_pkg::opcode_e'(ins[6:0]))
      rv_pkg::op_alu_reg: x[ins[11:7]] = ins[25] ? a * b : ins[30] ? a - b : a + b;
      rv_pkg::op_alu_imm: x[ins[11:7]] = (ins[14:12] == 3'd1) ? a << ins[24:20] :
                                         (ins[14:12] == 3'd5) ? a >> ins[24:20] : a + ii;
      rv_pkg::op_load:    x[ins[11:7]] = mem[(a + ii) >> 2];
      rv_pkg::op_lui:     x[ins[11:7]] = {ins[31:12], 12'b0};
      rv_pkg::op_auipc:   x[ins[11:7]] = pc + {ins[31:12], 12'b0};
      rv_pkg::op_store: begin
        mem[(a + si) >> 2] = b;
        st_adr.push_back(a + si);
        st_dat.push_back(b);
      end
      rv_pkg::op_branch: begin
        case (ins[14:12])
          3'd0:    nxt = (a == b) ? pc + bi : nxt;
          3'd1:    nxt = (a != b) ? pc + bi : nxt;
          3'd4:    nxt = ($signed(a) < $signed(b)) ? pc + bi : nxt;
          default: nxt = ($signed(a) >= $signed(b)) ? pc + bi : nxt;
        endcase
      end
      rv_pkg::op_jal: begin
        nxt          = pc + ji;
        x[ins[11:7]] = pc + 4;
      end
      default: begin // jalr
        nxt          = (a + ii) & ~32'd1;
        x[ins[11:7]] = pc + 4;
      end
    endcase
    x[0] = '0;
    if (nxt == pc) break;
    pc = nxt;
  end
endfunction

`endif

// File: dv/rv_pipeline_tb.sv
`timescale 1ns/1ps

module rv_pipeline_tb;

  localparam int          imem_depth = 256;
  localparam int          bus_words  = 128;         // Window plus dump region
  localparam logic [31:0] rand_seed  = 32'd42280;

  logic                          clock = 1'b0;
  logic                          reset;
  logic                          run;
  logic                          prog_we;
  logic [$clog2(imem_depth)-1:0] prog_addr;
  logic [31:0]                   prog_data;
  logic                          wb_cyc;
  logic                          wb_stb;
  logic                          wb_we;
  logic [31:0]                   wb_adr;
  logic [31:0]                   wb_dat_o;
  logic [3:0]                    wb_sel;
  logic [31:0]                   wb_dat_i = '0;
  logic                          wb_ack = 1'b0;

  // Bus view sampled at the falling edge
  logic        cyc_s = 1'b0;
  logic        stb_s = 1'b0;
  logic        we_s  = 1'b0;
  logic [31:0] adr_s = '0;
  logic [31:0] dat_s = '0;
  logic [3:0]  sel_s = '0;

  logic [31:0] prog [$];
  logic [31:0] st_adr [$];   // Expected stores in program order
  logic [31:0] st_dat [$];
  logic [31:0] model_mem [bus_words];
  logic [31:0] bus_mem [bus_words];
  logic [31:0] seed;
  logic [31:0] ack_seed;
  logic [1:0]  ack_wait;
  int          store_idx;
  int          watchdog_cycles;

  `include "rv_tb_model.svh"

  rv_pipeline_top #(.imem_depth(imem_depth), .reset_pc(32'h0)) u_rv_pipeline_top (
    .clock, .reset, .run, .prog_we, .prog_addr, .prog_data,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_o, .wb_sel, .wb_dat_i, .wb_ack
  );

  always #2 clock = ~clock; // 4 ns period

  task automatic fail_and_stop();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped on the first failure");
  endtask

  // Initial memory word hashed from the whole address
  function automatic logic [31:0] fill_word(input int addr);
    logic [31:0] state;
    state = rand_seed ^ (32'(addr) * 32'h9e37_79b9);
    void'(xorshift32(state));
    return xorshift32(state);
  endfunction

  always @(negedge clock) begin
    cyc_s <= wb_cyc;
    stb_s <= wb_stb;
    we_s  <= wb_we;
    adr_s <= wb_adr;
    dat_s <= wb_dat_o;
    sel_s <= wb_sel;
  end

  // ========================================
  // Wishbone slave with random ack delay
  // ========================================
  always @(posedge clock or posedge reset) begin : bus_slave
    logic [31:0] ack_rand;
    if (reset) begin
      for (int i = 0; i < bus_words; i++) bus_mem[i] <= fill_word(i);
      wb_ack    <= 1'b0;
      wb_dat_i  <= '0;
      ack_wait  <= 2'd0;
      store_idx <= 0;
      ack_seed  = rand_seed ^ 32'h5a5a_5a5a;
    end else begin
      assert (run || !(cyc_s || stb_s))
        else begin
          $display("A bus cycle started before run was raised");
          fail_and_stop();
        end
      wb_ack <= 1'b0;
      if (cyc_s && stb_s && !wb_ack) begin
        assert (sel_s == 4'hf)
          else begin
            $display("ERROR: wb_sel expected 0x%h actual 0x%h", 4'hf, sel_s);
            fail_and_stop();
          end
        assert (adr_s < 32'(4 * bus_words) && adr_s[1:0] == 2'b00)
          else begin
            $display("Bus address 0x%08h is outside the slave memory or unaligned", adr_s);
            fail_and_stop();
          end
        if (ack_wait != 2'd0) begin
          ack_wait <= ack_wait - 2'd1;
        end else begin
          wb_ack <= 1'b1;
          if (we_s) begin
            assert (store_idx < st_adr.size())
              else begin
                $display("A store appeared after all expected stores were seen");
                fail_and_stop();
              end
            assert (adr_s == st_adr[store_idx])
              else begin
                $display("ERROR: wb_adr expected 0x%08h actual 0x%08h",
                         st_adr[store_idx], adr_s);
                fail_and_stop();
              end
            assert (dat_s == st_dat[store_idx])
              else begin
                $display("ERROR: wb_dat_o expected 0x%08h actual 0x%08h",
                         st_dat[store_idx], dat_s);
                fail_and_stop();
              end
            bus_mem[adr_s[8:2]] <= dat_s;
            store_idx <= store_idx + 1;
          end else begin
            wb_dat_i <= bus_mem[adr_s[8:2]]; // Load data with the ack
          end
        end
      end else begin
        ack_rand = xorshift32(ack_seed);
        ack_wait <= ack_rand[1:0]; // Delay for the next transfer
      end
    end
  end

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    reset     = 1'b1;
    run       = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    seed      = rand_seed;
    gen_program(prog, seed);
    for (int i = 0; i < bus_words; i++) model_mem[i] = fill_word(i);
    run_model(prog, model_mem, st_adr, st_dat);
    watchdog_cycles = prog.size() * 20 + 200;
    $display("Program of %0d words, %0d stores expected", prog.size(), st_adr.size());

    repeat (4) @(posedge clock);
    reset <= 1'b0;
    for (int i = 0; i < imem_depth; i++) begin
      @(posedge clock);
      prog_we   <= 1'b1;
      prog_addr <= ($clog2(imem_depth))'(i);
      prog_data <= (i < prog.size()) ? prog[i] : rv_pkg::nop_instr; // Pad past the end
    end
    @(posedge clock);
    prog_we <= 1'b0;
    run     <= 1'b1;

    while (store_idx < st_adr.size()) @(posedge clock);
    repeat (30) @(posedge clock); // Room for any stray store
    $display("Result: PASSED");
    $finish;
  end

  // Watchdog counted from run
  initial begin
    wait (run);
    repeat (watchdog_cycles) @(posedge clock);
    $display("Timeout after %0d cycles with %0d of %0d stores seen",
             watchdog_cycles, store_idx, st_adr.size());
    fail_and_stop();
  end

endmodule

// File: files.f
+incdir+include
logic/rv_pkg.sv
logic/fetch_stage.sv
logic/register_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/rv_pipeline_top.sv
dv/rv_pipeline_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module rv_pipeline_tb -o rv_pipeline_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/rv_pipeline_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi
exit 0
